//--- sim.f
hdl/bus_pkg.sv
hdl/stream_pkg.sv
hdl/byte_lane_ram.sv
hdl/stream_rx_ack.sv
hdl/cycle_irq_timer.sv
hdl/mem_bus_ctrl.sv
hdl/mem_bus_top.sv
sim/tb_mem_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the memory-bus testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert --top-module tb_mem_bus \
  --Mdir obj_dir -o Vtb_mem_bus -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_mem_bus > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation passed"
exit 0

//--- sim/tb_mem_bus.sv
`timescale 1ns/100ps

module tb_mem_bus;
  import bus_pkg::*;
  import stream_pkg::*;

  localparam int ADDR_BITS     = 10;
  localparam int N_CHAN        = 5;
  localparam int NUM_ROUNDS    = 300;                     // Random operations
  localparam int N_TXN         = 2 * NUM_ROUNDS;          // RAM rounds take two transactions
  localparam int TIMEOUT_CYC   = 20 * N_TXN + 70000;      // Room for the irq wrap too
  localparam int IRQ_RUN       = 65536 + 64;              // Cycles past one full counter wrap
  localparam int KIND_RAM      = 0;
  localparam int KIND_TX       = 1;
  localparam int KIND_RX       = 2;

  logic       clk = 1'b0;
  logic       resetn;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  chan_vec_t  tx_valid;
  word_t      tx_data;
  chan_vec_t  tx_ready;
  chan_vec_t  rx_valid;
  chan_data_t rx_data;
  chan_vec_t  rx_ack;
  word_t      irq;

  word_t      lfsr_state;                                 // Random source
  logic [7:0] ram_model [1 << ADDR_BITS][4];              // Byte mirror of the RAM
  logic       written   [1 << ADDR_BITS];                 // Word holds known bytes
  int         reads_done [MAX_CHAN];                      // Receive reads completed
  int         acks_seen  [MAX_CHAN];                      // rx_ack pulses counted
  int         cur_rx_chan;                                // Receive channel of current txn, or -1
  logic       checks_on;                                  // Monitor active after reset
  logic [15:0] irq_model;                                 // Cycle count since reset release
  int         cycles_run;
  int         timeout_cnt;
  int         err_count;
  word_t      exp_irq;

  always #10 clk = ~clk;                                  // 20 ns period

  mem_bus_top #(
    .ADDR_BITS (ADDR_BITS),
    .N_CHAN    (N_CHAN)
  ) u_mem_bus_top (
    .clk      (clk),
    .resetn   (resetn),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_ready (tx_ready),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .rx_ack   (rx_ack),
    .irq      (irq)
  );

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_vec(input string name, input chan_vec_t exp, input chan_vec_t act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  // Galois form, taps 32 22 2 1
  function automatic word_t lfsr_next(input word_t s);
    word_t n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  function automatic word_t get_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);                 // One step per bit
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic word_t model_word(input int widx);
    word_t w;
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = ram_model[widx][b];
    end
    return w;
  endfunction

  // One bus transaction, valid held until ready, then one low cycle
  task automatic bus_txn(input word_t addr, input word_t wdata, input strb_t wstrb,
                         input logic instr, input int kind, input chan_idx_t ch,
                         input int stall, input word_t rx_word, output word_t rdata);
    chan_vec_t exp_tx;
    int        wait_cyc;
    @(posedge clk);
    mem_req.valid <= 1'b1;
    mem_req.instr <= instr;
    mem_req.addr  <= addr;
    mem_req.wdata <= wdata;
    mem_req.wstrb <= wstrb;
    cur_rx_chan = (kind == KIND_RX) ? int'(ch) : -1;
    if (kind == KIND_TX) begin
      tx_ready[ch] <= (stall == 0);                       // Sink held off for stall cycles
    end
    if (kind == KIND_RX) begin
      rx_valid[ch] <= (stall == 0);                       // Source empty for stall cycles
      rx_data[ch]  <= rx_word;
    end
    @(negedge clk);
    exp_tx = (kind == KIND_TX) ? (chan_vec_t'(1) << ch) : '0;
    check_vec("tx_valid", exp_tx, tx_valid);              // Strobe only in the start cycle
    check_word("tx_data", wdata, tx_data);
    wait_cyc = 0;
    do begin
      @(posedge clk);
      wait_cyc++;
      if (kind == KIND_TX) begin
        tx_ready[ch] <= (wait_cyc >= stall);
      end
      if (kind == KIND_RX) begin
        rx_valid[ch] <= (wait_cyc >= stall);
      end
      @(negedge clk);
      check_vec("tx_valid", '0, tx_valid);
    end while (!mem_rsp.ready);                           // Global timeout guards this loop
    if (wait_cyc <= stall) begin
      err_count++;
      $display("[ERROR] %0t ready came after %0d cycles while the far side stalled %0d",
               $time, wait_cyc, stall);
      stop_on_error();
    end
    rdata = mem_rsp.rdata;                                // Valid in the ready cycle
    @(posedge clk);
    mem_req.valid <= 1'b0;
    mem_req.wstrb <= '0;
    @(negedge clk);
    check_bit("mem_rsp.ready", 1'b0, mem_rsp.ready);      // Ready lasts one cycle
    check_vec("tx_valid", '0, tx_valid);
  endtask

  // Write with random strobes, then read back through a different alias
  task automatic ram_round();
    word_t addr;
    word_t wdata;
    word_t rdata;
    strb_t strb;
    int    widx;
    widx  = int'(get_bits(ADDR_BITS));
    addr  = (get_bits(20) << 12) | (word_t'(widx) << 2);
    addr[28] = 1'b0;                                      // Keeps clear of the stream window
    wdata = get_bits(32);
    strb  = strb_t'(get_bits(4));
    if (!written[widx]) begin
      strb = 4'hF;                                        // First write fills every byte
    end
    written[widx] = 1'b1;
    bus_txn(addr, wdata, strb, 1'b0, KIND_RAM, '0, 0, '0, rdata);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        ram_model[widx][b] = wdata[8*b +: 8];
      end
    end
    addr  = (get_bits(20) << 12) | (word_t'(widx) << 2);  // Upper bits wrap away
    addr[28] = 1'b0;
    wdata = get_bits(32);
    bus_txn(addr, wdata, '0, get_bits(1) != 0, KIND_RAM, '0, 0, '0, rdata);
    check_word("mem_rsp.rdata", model_word(widx), rdata);
  endtask

  task automatic tx_round();
    word_t     addr;
    word_t     wdata;
    word_t     rdata;
    chan_idx_t ch;
    int        stall;
    ch    = chan_idx_t'(int'(get_bits(3)) % N_CHAN);
    stall = int'(get_bits(2));
    addr  = STREAM_BASE + word_t'(8 * (int'(ch) + 1));    // Offset 8k
    wdata = get_bits(32);
    bus_txn(addr, wdata, 4'hF, 1'b0, KIND_TX, ch, stall, '0, rdata);
  endtask

  task automatic rx_round();
    word_t     addr;
    word_t     wdata;
    word_t     rdata;
    word_t     rx_word;
    chan_idx_t ch;
    int        stall;
    ch      = chan_idx_t'(int'(get_bits(3)) % N_CHAN);
    stall   = int'(get_bits(2));
    addr    = STREAM_BASE + word_t'(8 * (int'(ch) + 1) - 4);   // Offset 8k-4
    rx_word = get_bits(32);
    wdata   = get_bits(32);
    bus_txn(addr, wdata, '0, 1'b0, KIND_RX, ch, stall, rx_word, rdata);
    check_word("mem_rsp.rdata", rx_word, rdata);
  endtask

  // Cycle monitor for irq and the acknowledge counts
  always @(negedge clk) begin
    if (checks_on) begin
      exp_irq = '0;
      exp_irq[IRQ_FAST_BIT] = (irq_model[12:0] == 13'h1FFF);
      exp_irq[IRQ_SLOW_BIT] = (irq_model == 16'hFFFF);
      check_word("irq", exp_irq, irq);
      irq_model = irq_model + 16'd1;                      // Wraps with the DUT counter
      cycles_run++;
      if (mem_rsp.ready && cur_rx_chan >= 0) begin
        reads_done[cur_rx_chan]++;                        // Read counts before its ack
      end
      for (int k = 0; k < MAX_CHAN; k++) begin
        if (rx_ack[chan_idx_t'(k)]) begin
          acks_seen[k]++;
        end
        if (acks_seen[k] > reads_done[k]) begin
          err_count++;
          $display("[ERROR] %0t rx_ack of channel %0d outnumbers its completed reads",
                   $time, k + 1);
          stop_on_error();
        end
      end
    end
  end

  always @(posedge clk) begin
    timeout_cnt++;
    if (timeout_cnt > TIMEOUT_CYC) begin
      $display("[ERROR] %0t run did not finish within %0d cycles", $time, TIMEOUT_CYC);
      stop_on_error();
    end
  end

  initial begin
    int kind;
    resetn      = 1'b0;
    mem_req     = '0;
    tx_ready    = '0;
    rx_valid    = '0;
    rx_data     = '0;
    lfsr_state  = 32'd93;
    cur_rx_chan = -1;
    checks_on   = 1'b0;
    irq_model   = '0;
    cycles_run  = 0;
    timeout_cnt = 0;
    err_count   = 0;
    for (int k = 0; k < MAX_CHAN; k++) begin
      reads_done[k] = 0;
      acks_seen[k]  = 0;
    end
    for (int i = 0; i < (1 << ADDR_BITS); i++) begin
      written[i] = 1'b0;
    end
    repeat (16) @(posedge clk);                           // Reset for 16 cycles
    resetn <= 1'b1;
    checks_on = 1'b1;
    @(negedge clk);
    check_bit("mem_rsp.ready", 1'b0, mem_rsp.ready);      // Quiet outputs after release
    check_vec("tx_valid", '0, tx_valid);
    check_vec("rx_ack", '0, rx_ack);
    check_word("irq", '0, irq);
    for (int r = 0; r < NUM_ROUNDS; r++) begin
      kind = int'(get_bits(2));
      if (kind < 2) begin
        ram_round();                                      // Half the rounds hit RAM
      end else if (kind == 2) begin
        tx_round();
      end else begin
        rx_round();
      end
    end
    @(posedge clk);
    rx_valid <= '1;                                       // Let every owed ack drain
    repeat (5) @(posedge clk);
    for (int k = 0; k < MAX_CHAN; k++) begin
      check_word($sformatf("rx_ack count channel %0d", k + 1),
                 word_t'(reads_done[k]), word_t'(acks_seen[k]));
    end
    while (cycles_run < IRQ_RUN) begin
      @(posedge clk);                                     // Monitor covers the wrap
    end
    if (err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_on_error();
    end
  end

endmodule

//--- hdl/mem_bus_top.sv
`timescale 1ns/100ps

module mem_bus_top #(
  parameter int ADDR_BITS = 10,   // RAM word address width
  parameter int N_CHAN    = 5     // Live stream channels, 1 to MAX_CHAN
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  bus_pkg::mem_req_t      mem_req,    // From the core
  output bus_pkg::mem_rsp_t      mem_rsp,    // To the core
  output stream_pkg::chan_vec_t  tx_valid,   // One-cycle strobe per transmit channel
  output bus_pkg::word_t         tx_data,    // Shared by all transmit channels
  input  stream_pkg::chan_vec_t  tx_ready,   // Sink levels
  input  stream_pkg::chan_vec_t  rx_valid,   // Source levels
  input  stream_pkg::chan_data_t rx_data,    // Source words
  output stream_pkg::chan_vec_t  rx_ack,     // One pulse per consumed word
  output bus_pkg::word_t         irq         // Periodic interrupt lines
);
  import bus_pkg::*;
  import stream_pkg::*;

  strb_t                ram_we;          // Per-lane write enables
  logic [ADDR_BITS-1:0] ram_addr;        // RAM word address
  word_t                ram_wdata;
  word_t                ram_rdata;       // Registered RAM word
  chan_vec_t            rx_read_start;   // Receive read seen, one pulse

  // Bus decode, ready and read mux
  mem_bus_ctrl #(
    .ADDR_BITS (ADDR_BITS),
    .N_CHAN    (N_CHAN)
  ) u_mem_bus_ctrl (
    .clk           (clk),
    .resetn        (resetn),
    .mem_req       (mem_req),
    .mem_rsp       (mem_rsp),
    .tx_valid      (tx_valid),
    .tx_data       (tx_data),
    .tx_ready      (tx_ready),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .rx_read_start (rx_read_start),
    .ram_we        (ram_we),
    .ram_addr      (ram_addr),
    .ram_wdata     (ram_wdata),
    .ram_rdata     (ram_rdata)
  );

  // Program and data store
  byte_lane_ram #(
    .ADDR_BITS (ADDR_BITS)
  ) u_byte_lane_ram (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  // Receive side acknowledges
  stream_rx_ack #(
    .N_CHAN (N_CHAN)
  ) u_stream_rx_ack (
    .clk           (clk),
    .resetn        (resetn),
    .rx_read_start (rx_read_start),
    .rx_valid      (rx_valid),
    .rx_ack        (rx_ack)
  );

  // Timer interrupts
  cycle_irq_timer u_cycle_irq_timer (
    .clk    (clk),
    .resetn (resetn),
    .irq    (irq)
  );

endmodule

//--- hdl/mem_bus_ctrl.sv
`timescale 1ns/100ps

module mem_bus_ctrl #(
  parameter int ADDR_BITS = 10,   // RAM word address width
  parameter int N_CHAN    = 5     // Live stream channels
) (
  input  logic                   clk,
  input  logic                   resetn,
  input  bus_pkg::mem_req_t      mem_req,
  output bus_pkg::mem_rsp_t      mem_rsp,
  output stream_pkg::chan_vec_t  tx_valid,        // Strobe at transaction start
  output bus_pkg::word_t         tx_data,
  input  stream_pkg::chan_vec_t  tx_ready,
  input  stream_pkg::chan_vec_t  rx_valid,
  input  stream_pkg::chan_data_t rx_data,
  output stream_pkg::chan_vec_t  rx_read_start,   // Read of a receive channel begins
  output bus_pkg::strb_t         ram_we,
  output logic [ADDR_BITS-1:0]   ram_addr,
  output bus_pkg::word_t         ram_wdata,
  input  bus_pkg::word_t         ram_rdata
);
  import bus_pkg::*;
  import stream_pkg::*;

  logic      valid_q;      // Bus valid in the previous cycle
  logic      txn_start;    // First valid cycle after a low one
  logic      pending;      // Valid and not yet answered
  logic      in_win;       // Address inside the stream window
  logic      dir_rx;       // Receive half of a channel slot
  chan_idx_t field;        // Raw channel field of the offset
  chan_idx_t chan;         // Zero-based channel index
  logic      chan_ok;      // Field names a live channel
  logic      tx_hit;
  logic      rx_hit;
  chan_vec_t chan_sel;     // One-hot of chan
  logic      ready_nxt;    // Ready rule for the current address
  logic      ready_q;
  logic      sel_rx_q;     // Read data comes from a receive channel
  chan_idx_t sel_chan_q;   // Which receive channel

  assign txn_start = mem_req.valid && !valid_q;
  assign pending   = mem_req.valid && !ready_q;

  // Window decode
  assign in_win = (mem_req.addr >= STREAM_BASE) &&
                  (mem_req.addr < STREAM_BASE + STREAM_SPAN);
  assign dir_rx = mem_req.addr[DIR_BIT];
  assign field  = mem_req.addr[CHAN_MSB:CHAN_LSB];
  assign chan   = dir_rx ? field : field - 3'd1;   // Transmit slots start at field 1

  // Word aligned, live channel, and no transmit slot at offset 0
  assign chan_ok = in_win && (mem_req.addr[1:0] == 2'b00) &&
                   (int'(chan) < N_CHAN) && (dir_rx || (field != 3'd0));

  assign tx_hit   = chan_ok && !dir_rx;
  assign rx_hit   = chan_ok && dir_rx;
  assign chan_sel = chan_vec_t'(1'b1) << chan;

  // Channel strobes only in the start cycle
  assign tx_valid      = (txn_start && tx_hit) ? chan_sel : '0;
  assign rx_read_start = (txn_start && rx_hit) ? chan_sel : '0;
  assign tx_data       = mem_req.wdata;   // Same word for every channel

  // Ready follows the far side of a stream slot, RAM answers at once
  always_comb begin
    if (tx_hit) begin
      ready_nxt = tx_ready[chan];    // Wait for the sink
    end else if (rx_hit) begin
      ready_nxt = rx_valid[chan];    // Wait for a word
    end else begin
      ready_nxt = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q    <= 1'b0;
      ready_q    <= 1'b0;
      sel_rx_q   <= 1'b0;
      sel_chan_q <= '0;
    end else begin
      valid_q <= mem_req.valid;
      ready_q <= pending && ready_nxt;   // Retested every waiting cycle
      if (pending) begin
        sel_rx_q   <= rx_hit;            // Read source for the ready cycle
        sel_chan_q <= chan;
      end
    end
  end

  // RAM port, only outside the stream window
  assign ram_we    = (pending && !in_win) ? mem_req.wstrb : '0;
  assign ram_addr  = mem_req.addr[ADDR_BITS+1:2];   // Wraps over the RAM size
  assign ram_wdata = mem_req.wdata;

  assign mem_rsp.ready = ready_q;
  assign mem_rsp.rdata = sel_rx_q ? rx_data[sel_chan_q] : ram_rdata;

  // Completion is a single pulse, the core must drop valid in between
  a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
    mem_rsp.ready |=> !mem_rsp.ready);

  // At most one transmit channel strobed per transaction start
  a_tx_onehot: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0(tx_valid));

endmodule

//--- hdl/cycle_irq_timer.sv
`timescale 1ns/100ps

module cycle_irq_timer (
  input  logic           clk,
  input  logic           resetn,
  output bus_pkg::word_t irq     // Only the two timer lines are used
);
  import bus_pkg::*;

  logic [15:0] count_cycle;   // Free running, wraps at 16 bits

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count_cycle <= 16'd0;
    end else begin
      count_cycle <= count_cycle + 16'd1;
    end
  end

  // Lines are high for one cycle per period
  always_comb begin
    irq               = '0;
    irq[IRQ_FAST_BIT] = &count_cycle[12:0];   // Low 13 bits all ones
    irq[IRQ_SLOW_BIT] = &count_cycle;         // Full count all ones
  end

endmodule

//--- hdl/stream_rx_ack.sv
`timescale 1ns/100ps

module stream_rx_ack #(
  parameter int N_CHAN = 5   // Live receive channels
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  stream_pkg::chan_vec_t rx_read_start,   // One pulse per core read
  input  stream_pkg::chan_vec_t rx_valid,        // Source has a word
  output stream_pkg::chan_vec_t rx_ack           // Word consumed
);
  import stream_pkg::*;

  for (genvar g = 0; g < MAX_CHAN; g++) begin : g_chan
    if (g < N_CHAN) begin : g_live
      logic [7:0] seen_cnt;   // Reads started by the core
      logic [7:0] ack_cnt;    // Acknowledges already given
      logic       owed;       // A read is still unacknowledged
      logic       ack_q;

      assign owed = (seen_cnt != ack_cnt) && rx_valid[g];

      always_ff @(posedge clk) begin
        if (!resetn) begin
          seen_cnt <= 8'd0;
          ack_cnt  <= 8'd0;
          ack_q    <= 1'b0;
        end else begin
          if (rx_read_start[g]) begin
            seen_cnt <= seen_cnt + 8'd1;
          end
          ack_q <= owed;              // Back to back when several are owed
          if (owed) begin
            ack_cnt <= ack_cnt + 8'd1;
          end
        end
      end

      assign rx_ack[g] = ack_q;

      // Source still offers the word while it is acknowledged
      a_ack_valid: assert property (@(posedge clk) disable iff (!resetn)
        ack_q |-> rx_valid[g]);
    end else begin : g_idle
      assign rx_ack[g] = 1'b0;        // Channel not built
    end
  end

endmodule

//--- hdl/byte_lane_ram.sv
`timescale 1ns/100ps

module byte_lane_ram #(
  parameter int ADDR_BITS = 10   // Word address width
) (
  input  logic                 clk,
  input  bus_pkg::strb_t       we,      // One enable per byte lane
  input  logic [ADDR_BITS-1:0] addr,    // Word address
  input  bus_pkg::word_t       wdata,
  output bus_pkg::word_t       rdata    // Registered, old contents on a write
);

  localparam int DEPTH = 2 ** ADDR_BITS;   // Words in the RAM
  localparam int LANES = $bits(we);        // Byte lanes per word

  // One byte-wide array per lane, all sharing the address
  for (genvar b = 0; b < LANES; b++) begin : g_lane
    logic [7:0] lane_mem [DEPTH];
    logic [7:0] rd_q;                      // Lane read register

    always_ff @(posedge clk) begin
      if (we[b]) begin
        lane_mem[addr] <= wdata[8*b +: 8];   // Only strobed bytes change
      end
      rd_q <= lane_mem[addr];                // Read before write
    end

    assign rdata[8*b +: 8] = rd_q;
  end

endmodule

//--- hdl/stream_pkg.sv
package stream_pkg;

  localparam int MAX_CHAN = 7;   // Limit of the 3-bit channel field

  typedef logic [2:0]          chan_idx_t;   // Zero-based channel index
  typedef logic [MAX_CHAN-1:0] chan_vec_t;   // Bit k-1 belongs to channel k

  // One receive word per channel, element k-1 for channel k
  typedef bus_pkg::word_t [MAX_CHAN-1:0] chan_data_t;

  // Window offset layout
  // Transmit channel k at offset 8k, bit 2 clear, channel field = k
  // Receive channel k at offset 8k-4, bit 2 set, channel field = k-1
  localparam int CHAN_MSB = 5;   // Top of the channel field
  localparam int CHAN_LSB = 3;   // Bottom of the channel field
  localparam int DIR_BIT  = 2;   // Set for receive, clear for transmit

endpackage

//--- hdl/bus_pkg.sv
package bus_pkg;

  typedef logic [31:0] word_t;   // One bus word
  typedef logic [3:0]  strb_t;   // Byte write strobes, bit n enables byte n

  // Request from the core, held steady from valid until ready
  typedef struct packed {
    logic  valid;   // Transaction request level
    logic  instr;   // Instruction fetch, served like a data read
    word_t addr;    // Byte address
    word_t wdata;   // Write data, also the shared transmit word
    strb_t wstrb;   // All zero on reads
  } mem_req_t;

  // Response back to the core
  typedef struct packed {
    logic  ready;   // One-cycle completion pulse
    word_t rdata;   // Sampled by the core with ready
  } mem_rsp_t;

  // Memory map
  // Stream window holds the channel registers, everything else is RAM
  localparam word_t STREAM_BASE = 32'h1000_0000;  // Base of the stream window
  localparam word_t STREAM_SPAN = 32'd64;         // Window size in bytes

  // Interrupt line positions in the irq word
  localparam int IRQ_FAST_BIT = 4;   // Once every 8192 cycles
  localparam int IRQ_SLOW_BIT = 5;   // Once every 65536 cycles

endpackage
